/* compile.f */
+incdir+tests
design/gomoku_pkg.sv
design/eval_fsm.sv
design/scan_counter.sv
design/window_matcher.sv
design/score_accumulator.sv
design/gomoku_eval_top.sv
tests/tb_gomoku_eval.sv

/* design/eval_fsm.sv */
`timescale 1ns/1ps

module eval_fsm (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_start,
    input  logic i_scan_last,
    output logic o_scan_clear,
    output logic o_scan_step,
    output logic o_acc_clear,
    output logic o_acc_add,
    output logic o_acc_finish,
    output logic o_finish
);

    import gomoku_pkg::*;

    eval_state_t state_r;
    eval_state_t state_nxt;
    logic        start_ok;
    logic        finish_r;

    assign start_ok = (state_r == S_IDLE) && i_start; // Starts elsewhere are dropped.

    // Counter and sums both restart from the start pulse.
    assign o_scan_clear = start_ok;
    assign o_acc_clear  = start_ok;

    // One window per cycle while scanning.
    assign o_scan_step  = (state_r == S_SCAN);
    assign o_acc_add    = (state_r == S_SCAN);

    assign o_acc_finish = (state_r == S_FINISH);
    assign o_finish     = finish_r;

    always_comb begin
        state_nxt = state_r;
        case (state_r)
            S_IDLE: begin
                if (start_ok) begin
                    state_nxt = S_SCAN;
                end
            end
            S_SCAN: begin
                // Last window is added on this same edge.
                if (i_scan_last) begin
                    state_nxt = S_FINISH;
                end
            end
            S_FINISH: begin
                state_nxt = S_IDLE;
            end
            default: begin
                state_nxt = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state_r  <= S_IDLE;
            finish_r <= 1'b0;
        end else begin
            state_r  <= state_nxt;
            finish_r <= (state_r == S_FINISH); // Lines up with the score register.
        end
    end

endmodule

/* design/gomoku_eval_top.sv */
`timescale 1ns/1ps

module gomoku_eval_top #(
    parameter int BOARD_DIM = 15
) (
    input  logic                                        i_clk,
    input  logic                                        i_rst_n,
    input  logic                                        i_start,
    input  gomoku_pkg::cell_t [BOARD_DIM*BOARD_DIM-1:0] i_board,
    output gomoku_pkg::score_t                          o_score,
    output logic                                        o_finish
);

    import gomoku_pkg::*;

    localparam int IDX_W = $clog2(BOARD_DIM);

    logic             scan_clear;
    logic             scan_step;
    logic             scan_last;
    logic [IDX_W-1:0] row;
    logic [IDX_W-1:0] col;
    logic             acc_clear;
    logic             acc_add;
    logic             acc_finish;
    weight_t          black_weight;
    weight_t          white_weight;

    eval_fsm u_fsm (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_start      (i_start),
        .i_scan_last  (scan_last),
        .o_scan_clear (scan_clear),
        .o_scan_step  (scan_step),
        .o_acc_clear  (acc_clear),
        .o_acc_add    (acc_add),
        .o_acc_finish (acc_finish),
        .o_finish     (o_finish)
    );

    scan_counter #(
        .BOARD_DIM (BOARD_DIM)
    ) u_counter (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_clear (scan_clear),
        .i_step  (scan_step),
        .o_row   (row),
        .o_col   (col),
        .o_last  (scan_last)
    );

    // Vertical windows only.
    window_matcher #(
        .BOARD_DIM (BOARD_DIM)
    ) u_matcher (
        .i_board        (i_board),
        .i_row          (row),
        .i_col          (col),
        .o_black_weight (black_weight),
        .o_white_weight (white_weight)
    );

    score_accumulator u_acc (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_clear        (acc_clear),
        .i_add          (acc_add),
        .i_finish       (acc_finish),
        .i_black_weight (black_weight),
        .i_white_weight (white_weight),
        .o_score        (o_score)
    );

endmodule

/* design/gomoku_pkg.sv */
package gomoku_pkg;

    // Board cell encoding.
    typedef logic [1:0] cell_t;

    localparam cell_t CELL_BLACK = 2'd0;
    localparam cell_t CELL_WHITE = 2'd1;
    localparam cell_t CELL_EMPTY = 2'd2;

    // Per-window weight of one colour.
    typedef logic [23:0] weight_t;

    // Running sums and the final black minus white score.
    typedef logic signed [31:0] score_t;

    localparam weight_t W_FIVE         = 24'd1000000;
    localparam weight_t W_FOUR         = 24'd100000;
    localparam weight_t W_BLOCKED_FOUR = 24'd10000;
    localparam weight_t W_THREE        = 24'd1000;

    typedef enum logic [1:0] {
        S_IDLE,
        S_SCAN,
        S_FINISH
    } eval_state_t;

endpackage

/* design/scan_counter.sv */
`timescale 1ns/1ps

module scan_counter #(
    parameter  int BOARD_DIM = 15,
    localparam int IDX_W     = $clog2(BOARD_DIM)
) (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_clear,
    input  logic             i_step,
    output logic [IDX_W-1:0] o_row,
    output logic [IDX_W-1:0] o_col,
    output logic             o_last
);

    localparam logic [IDX_W-1:0] LAST_ROW = IDX_W'(BOARD_DIM - 5);
    localparam logic [IDX_W-1:0] LAST_COL = IDX_W'(BOARD_DIM - 1);

    logic [IDX_W-1:0] row_r;
    logic [IDX_W-1:0] col_r;
    logic             row_wrap;

    assign row_wrap = (row_r == LAST_ROW);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n || i_clear) begin
            row_r <= '0;
            col_r <= '0;
        end else if (i_step) begin
            if (row_wrap) begin
                row_r <= '0;
                // Next column, back to the first after the last one.
                col_r <= (col_r == LAST_COL) ? '0 : col_r + 1'b1;
            end else begin
                row_r <= row_r + 1'b1;
            end
        end
    end

    assign o_row  = row_r;
    assign o_col  = col_r;
    assign o_last = row_wrap && (col_r == LAST_COL); // Final window start.

endmodule

/* design/score_accumulator.sv */
`timescale 1ns/1ps

module score_accumulator (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_clear,
    input  logic                i_add,
    input  logic                i_finish,
    input  gomoku_pkg::weight_t i_black_weight,
    input  gomoku_pkg::weight_t i_white_weight,
    output gomoku_pkg::score_t  o_score
);

    import gomoku_pkg::*;

    score_t black_sum;
    score_t white_sum;
    score_t score_r;

    // Weights are unsigned, zero extended into the sums.
    always_ff @(posedge i_clk) begin
        if (!i_rst_n || i_clear) begin
            black_sum <= '0;
            white_sum <= '0;
        end else if (i_add) begin
            black_sum <= black_sum + score_t'(i_black_weight);
            white_sum <= white_sum + score_t'(i_white_weight);
        end
    end

    // Result holds until the next finish.
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            score_r <= '0;
        end else if (i_finish) begin
            score_r <= black_sum - white_sum;
        end
    end

    assign o_score = score_r;

endmodule

/* design/window_matcher.sv */
`timescale 1ns/1ps

module window_matcher #(
    parameter  int BOARD_DIM = 15,
    localparam int IDX_W     = $clog2(BOARD_DIM)
) (
    input  gomoku_pkg::cell_t [BOARD_DIM*BOARD_DIM-1:0] i_board,
    input  logic [IDX_W-1:0]                            i_row,
    input  logic [IDX_W-1:0]                            i_col,
    output gomoku_pkg::weight_t                         o_black_weight,
    output gomoku_pkg::weight_t                         o_white_weight
);

    import gomoku_pkg::*;

    cell_t [5:0] win;     // win[0] is the top cell of the window.
    logic        six_ok;  // Room for a sixth cell below.

    // Weight of one window for colour x against opponent o.
    function automatic weight_t weigh_colour(
        input cell_t [5:0] c,
        input cell_t       x,
        input cell_t       o,
        input logic        six
    );
        weight_t w;
        logic    core_four;
        logic    is_five;
        logic    open_four;
        logic    blocked_four;
        logic    open_three;

        w         = '0;
        core_four = (c[1] == x) && (c[2] == x) && (c[3] == x) && (c[4] == x);
        is_five   = (c[0] == x) && core_four;

        open_four = six && core_four
                    && (c[0] == CELL_EMPTY) && (c[5] == CELL_EMPTY);

        // Either end may carry the opponent stone.
        blocked_four = six && core_four
                       && (((c[0] == CELL_EMPTY) && (c[5] == o))
                           || ((c[0] == o) && (c[5] == CELL_EMPTY)));

        open_three = (c[0] == CELL_EMPTY) && (c[1] == x) && (c[2] == x)
                     && (c[3] == x) && (c[4] == CELL_EMPTY);

        if (is_five) begin
            w = w + W_FIVE;
        end
        if (open_four) begin
            w = w + W_FOUR;
        end
        if (blocked_four) begin
            w = w + W_BLOCKED_FOUR;
        end
        if (open_three) begin
            w = w + W_THREE;
        end
        return w;
    endfunction

    assign six_ok = (int'(i_row) <= BOARD_DIM - 6);

    always_comb begin
        int base;
        int last_r;

        base = int'(i_row) * BOARD_DIM + int'(i_col);
        for (int k = 0; k < 5; k++) begin
            win[k] = i_board[base + k * BOARD_DIM];
        end
        // Sixth cell would fall off the bottom edge on the last row.
        if (six_ok) begin
            last_r = base + 5 * BOARD_DIM;
        end else begin
            last_r = base + 4 * BOARD_DIM;
        end
        win[5] = i_board[last_r];
    end

    assign o_black_weight = weigh_colour(win, CELL_BLACK, CELL_WHITE, six_ok);
    assign o_white_weight = weigh_colour(win, CELL_WHITE, CELL_BLACK, six_ok);

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then scan the log.
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ps --top-module tb_gomoku_eval \
    -f compile.f -o tb_sim \
    && ./obj_dir/tb_sim 2>&1 | tee sim.log \
    || { echo "Build or simulation error"; exit 1; }
grep -q "test failed" sim.log && exit 1
exit 0

/* tests/score_model.svh */
`ifndef SCORE_MODEL_SVH
`define SCORE_MODEL_SVH

// Reference scorer for vertical windows. Needs DIM and board_t in scope.
// Cells past the bottom edge read as code 3, which never matches a stone or an empty cell.
function automatic int window_value(input board_t b, input int row, input int col,
                                    input cell_t me, input cell_t opp);
    cell_t c [6];
    int    v;
    bit    mid_four;

    for (int k = 0; k < 6; k++) begin
        c[k] = (row + k < DIM) ? b[(row + k) * DIM + col] : 2'd3;
    end
    v        = 0;
    mid_four = (c[1] == me) && (c[2] == me) && (c[3] == me) && (c[4] == me);
    if (mid_four && (c[0] == me)) begin
        v = v + int'(W_FIVE);
    end
    if (mid_four && (c[0] == CELL_EMPTY) && (c[5] == CELL_EMPTY)) begin
        v = v + int'(W_FOUR);
    end
    if (mid_four && (((c[0] == CELL_EMPTY) && (c[5] == opp))
                     || ((c[0] == opp) && (c[5] == CELL_EMPTY)))) begin
        v = v + int'(W_BLOCKED_FOUR);
    end
    if ((c[0] == CELL_EMPTY) && (c[1] == me) && (c[2] == me) && (c[3] == me)
        && (c[4] == CELL_EMPTY)) begin
        v = v + int'(W_THREE);
    end
    return v;
endfunction

// Black minus white over every window start of every column.
function automatic int model_score(input board_t b);
    int total;

    total = 0;
    for (int col = 0; col < DIM; col++) begin
        for (int row = 0; row <= DIM - 5; row++) begin
            total = total + window_value(b, row, col, CELL_BLACK, CELL_WHITE)
                          - window_value(b, row, col, CELL_WHITE, CELL_BLACK);
        end
    end
    return total;
endfunction

`endif

/* tests/tb_gomoku_eval.sv */
`timescale 1ns/1ps

module tb_gomoku_eval;

    import gomoku_pkg::*;

    localparam int DIM             = 15;
    localparam int CELLS           = DIM * DIM;
    localparam int FINISH_EDGE     = DIM * (DIM - 4) + 1;
    localparam int EVAL_LIMIT      = 2 * FINISH_EDGE;
    localparam int NUM_RANDOM      = 40;
    localparam int NUM_EVALS       = 1 + NUM_RANDOM + 2 + 2 + 3;
    localparam int WATCHDOG_CYCLES = NUM_EVALS * 200 + 1000;

    typedef cell_t [CELLS-1:0] board_t;

    logic        i_clk;
    logic        i_rst_n;
    logic        i_start;
    board_t      i_board;
    score_t      o_score;
    logic        o_finish;

    int          errors;
    int          last_score;
    logic [31:0] rng_state;

    `include "score_model.svh"

    gomoku_eval_top #(
        .BOARD_DIM (DIM)
    ) i_dut (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_start  (i_start),
        .i_board  (i_board),
        .o_score  (o_score),
        .o_finish (o_finish)
    );

    always #5 i_clk = ~i_clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function int rand_below(input int range);
        rng_state = lcg_step(rng_state);
        return int'(rng_state[30:16]) % range; // Upper bits, low ones cycle fast.
    endfunction

    task automatic check_value(input string name, input logic signed [31:0] got,
                               input logic signed [31:0] expected);
        if (got !== expected) begin
            errors++;
            $display("** Error at %0t: %s = %0d, expected %0d", $time, name, got, expected);
        end
    endtask

    // Biased towards stones, plus a few planted vertical runs.
    task automatic make_random_board(output board_t b);
        int    r;
        int    runs;
        int    col;
        int    len;
        int    top;
        cell_t stone;

        for (int i = 0; i < CELLS; i++) begin
            r = rand_below(16);
            if (r < 4) begin
                b[i] = CELL_BLACK;
            end else if (r < 8) begin
                b[i] = CELL_WHITE;
            end else if (r < 15) begin
                b[i] = CELL_EMPTY;
            end else begin
                b[i] = 2'd3; // Unused code.
            end
        end
        runs = 1 + rand_below(4);
        for (int k = 0; k < runs; k++) begin
            col   = rand_below(DIM);
            len   = 3 + rand_below(3);
            top   = rand_below(DIM - len + 1);
            stone = (rand_below(2) == 0) ? CELL_BLACK : CELL_WHITE;
            for (int j = 0; j < len; j++) begin
                b[(top + j) * DIM + col] = stone;
            end
            // Open ends half the time.
            if (rand_below(2) == 0) begin
                if (top > 0) begin
                    b[(top - 1) * DIM + col] = CELL_EMPTY;
                end
                if (top + len < DIM) begin
                    b[(top + len) * DIM + col] = CELL_EMPTY;
                end
            end
        end
    endtask

    function automatic board_t swap_colours(input board_t b);
        board_t s;

        s = b;
        for (int i = 0; i < CELLS; i++) begin
            if (b[i] == CELL_BLACK) begin
                s[i] = CELL_WHITE;
            end else if (b[i] == CELL_WHITE) begin
                s[i] = CELL_BLACK;
            end
        end
        return s;
    endfunction

    // One evaluation. A second start goes out after edge restart_at when it is positive.
    task automatic run_eval(input board_t b, input int restart_at, output int got);
        int n;
        bit done;

        n       = 0;
        done    = 1'b0;
        i_board = b;
        i_start = 1'b1;
        @(posedge i_clk);
        #1;
        i_start = 1'b0;
        check_value("o_finish", 32'(o_finish), 0);
        while (!done && n < EVAL_LIMIT) begin
            @(posedge i_clk);
            #1;
            n++;
            i_start = (n == restart_at);
            if (o_finish) begin
                done = 1'b1;
            end else begin
                check_value("o_score", o_score, last_score); // Old result during the scan.
            end
        end
        i_start = 1'b0;
        if (!done) begin
            errors++;
            $display("No o_finish pulse within %0d cycles of the start at %0t",
                     EVAL_LIMIT, $time);
        end else begin
            check_value("finish edge", n, FINISH_EDGE);
        end
        check_value("o_score", o_score, model_score(b));
        got        = o_score;
        last_score = o_score;
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            @(posedge i_clk);
            #1;
            check_value("o_finish", 32'(o_finish), 0);
            check_value("o_score", o_score, last_score);
        end
    endtask

    initial begin
        board_t a;
        int     got_a;
        int     got_s;

        errors     = 0;
        last_score = 0;
        rng_state  = 32'h1af1_75f5;
        i_clk      = 1'b0;
        i_rst_n    = 1'b0;
        i_start    = 1'b0;
        i_board    = {CELLS{CELL_EMPTY}};
        repeat (5) @(posedge i_clk);
        #1;
        i_rst_n = 1'b1;

        expect_quiet(10); // Idle after reset.
        run_eval({CELLS{CELL_EMPTY}}, -1, got_a);
        check_value("empty board o_score", got_a, 0);
        expect_quiet(3);

        for (int t = 0; t < NUM_RANDOM; t++) begin
            make_random_board(a);
            run_eval(a, -1, got_a);
            expect_quiet(2);
        end

        // Colour swap.
        make_random_board(a);
        run_eval(a, -1, got_a);
        run_eval(swap_colours(a), -1, got_s);
        check_value("swapped o_score", got_s, -model_score(a));
        expect_quiet(2);

        // Starts during the scan and in S_FINISH.
        make_random_board(a);
        run_eval(a, 40, got_a);
        expect_quiet(FINISH_EDGE + 4);
        make_random_board(a);
        run_eval(a, FINISH_EDGE - 1, got_a);
        expect_quiet(FINISH_EDGE + 4);

        for (int t = 0; t < 3; t++) begin
            make_random_board(a);
            run_eval(a, -1, got_a);
        end
        expect_quiet(2);

        $display("Finished %0d evaluations with %0d errors", NUM_EVALS, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge i_clk);
        $display("Watchdog expired after %0d cycles, the run did not complete",
                 WATCHDOG_CYCLES);
        $display("test failed");
        $finish;
    end

endmodule
